//--- verilog/dcache_pkg.sv
// data cache shared types
`default_nettype none

package dcache_pkg;

  // geometry
  localparam int num_way     = 4;
  localparam int num_set     = 8;
  localparam int way_bits    = 2;
  localparam int set_bits    = 3;
  localparam int offset_bits = 3;
  localparam int tag_bits    = 26;
  localparam int data_bits   = 64;

  // 32-bit byte address as seen by the cache
  typedef struct packed {
    logic [tag_bits-1:0]    tag;
    logic [set_bits-1:0]    set_index;
    // byte within the word, not used for lookup
    logic [offset_bits-1:0] offset;
  } cache_addr_t;

  // one stored line, a single 64-bit word
  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
  } cache_line_t;

  // one bit per way
  typedef logic [num_way-1:0] way_mask_t;

  // encoded way number
  typedef logic [way_bits-1:0] way_index_t;

  // line leaving the cache on replacement
  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    // offset is always zero here
    cache_addr_t          addr;
    logic [data_bits-1:0] data;
  } evict_line_t;

endpackage

`default_nettype wire

//--- verilog/write_steer.sv
// write way steering
`default_nettype none
`timescale 1ns/1ps

module write_steer (
  input  logic                  wr_en,
  input  logic                  wr_fill,
  input  dcache_pkg::way_mask_t wr_hits,
  input  dcache_pkg::way_mask_t victim,
  output dcache_pkg::way_mask_t way_write,
  output logic                  alloc,
  output logic                  wr_hit
);

  import dcache_pkg::*;

  logic store_hit;
  logic fill_miss;

  // line present in some way of the write set
  assign wr_hit = |wr_hits;

  // a hit always goes to the hit way, store or fill alike
  assign store_hit = wr_en && wr_hit;

  // only a fill may allocate
  assign fill_miss = wr_en && wr_fill && !wr_hit;

  // tree moves only when a new line is brought in
  assign alloc = fill_miss;

  always_comb begin
    way_write = '0;
    for (int w = 0; w < num_way; w++) begin
      if (store_hit) begin
        way_write[w] = wr_hits[w];
      end else if (fill_miss) begin
        way_write[w] = victim[w];
      end
    end
    // store miss leaves way_write clear, no write allocate
  end

endmodule

`default_nettype wire

//--- verilog/cache_way.sv
// one cache way
`default_nettype none
`timescale 1ns/1ps

module cache_way (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             write,
  input  dcache_pkg::cache_addr_t          rd_addr,
  input  dcache_pkg::cache_addr_t          wr_addr,
  input  logic [dcache_pkg::data_bits-1:0] wr_data,
  input  logic                             wr_dirty,
  input  logic                             wr_valid,
  output logic                             rd_hit,
  output dcache_pkg::cache_line_t          rd_line,
  output logic                             wr_hit,
  output dcache_pkg::cache_line_t          set_line
);

  import dcache_pkg::*;

  // one entry per set
  cache_line_t lines [num_set];

  cache_line_t new_line;

  // lookups
  assign rd_line = lines[rd_addr.set_index];
  assign set_line = lines[wr_addr.set_index];

  assign rd_hit = rd_line.valid && (rd_line.tag == rd_addr.tag);
  assign wr_hit = set_line.valid && (set_line.tag == wr_addr.tag);

  // entry written on a steered write
  always_comb begin
    new_line.valid = wr_valid;
    new_line.dirty = wr_dirty;
    new_line.tag   = wr_addr.tag;
    new_line.data  = wr_data;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_set; s++) begin
        lines[s].valid <= 1'b0;
        lines[s].dirty <= 1'b0;
      end
    end else if (write) begin
      lines[wr_addr.set_index] <= new_line;
    end
  end

endmodule

`default_nettype wire

//--- verilog/plru_tree.sv
// tree pseudo-lru per set
`default_nettype none
`timescale 1ns/1ps

module plru_tree (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [dcache_pkg::set_bits-1:0]   set_index,
  input  logic                              alloc,
  output dcache_pkg::way_mask_t             victim,
  output dcache_pkg::way_index_t            victim_way
);

  import dcache_pkg::*;

  // root picks the half, left and right pick within it
  logic [num_set-1:0] root;
  logic [num_set-1:0] left;
  logic [num_set-1:0] right;

  logic root_bit;
  logic left_bit;
  logic right_bit;

  assign root_bit  = root[set_index];
  assign left_bit  = left[set_index];
  assign right_bit = right[set_index];

  // ways 0/1 under left, 2/3 under right
  assign victim_way = {root_bit, root_bit ? right_bit : left_bit};

  always_comb begin
    victim = '0;
    for (int w = 0; w < num_way; w++) begin
      victim[w] = (victim_way == way_index_t'(w));
    end
  end

  // flip the bits along the path just taken
  always_ff @(posedge clock) begin
    if (reset) begin
      root  <= '0;
      left  <= '0;
      right <= '0;
    end else if (alloc) begin
      root[set_index] <= ~root_bit;
      if (root_bit) begin
        right[set_index] <= ~right_bit;
      end else begin
        left[set_index] <= ~left_bit;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/hit_select.sv
// read hit and victim selection
`default_nettype none
`timescale 1ns/1ps

module hit_select (
  input  dcache_pkg::way_mask_t                                rd_hits,
  input  dcache_pkg::cache_line_t [dcache_pkg::num_way-1:0]    rd_lines,
  input  dcache_pkg::cache_line_t [dcache_pkg::num_way-1:0]    set_lines,
  input  dcache_pkg::way_index_t                               victim_way,
  input  logic [dcache_pkg::set_bits-1:0]                      wr_set,
  output logic                                                 rd_hit,
  output logic [dcache_pkg::data_bits-1:0]                     rd_data,
  output dcache_pkg::evict_line_t                              evict
);

  import dcache_pkg::*;

  way_index_t  rd_way;
  cache_line_t victim_line;

  // encode the read hit vector
  always_comb begin
    rd_way = '0;
    for (int w = 0; w < num_way; w++) begin
      if (rd_hits[w]) begin
        rd_way = way_index_t'(w);
      end
    end
  end

  assign rd_hit = |rd_hits;

  // zero on a miss
  always_comb begin
    if (rd_hit) begin
      rd_data = rd_lines[rd_way].data;
    end else begin
      rd_data = '0;
    end
  end

  // line that the next fill of this set would replace
  assign victim_line = set_lines[victim_way];

  always_comb begin
    evict.valid          = victim_line.valid;
    evict.dirty          = victim_line.dirty;
    evict.addr.tag       = victim_line.tag;
    evict.addr.set_index = wr_set;
    // whole-word line, so no byte offset
    evict.addr.offset    = '0;
    evict.data           = victim_line.data;
  end

endmodule

`default_nettype wire

//--- verilog/dcache.sv
// four-way data cache
`default_nettype none
`timescale 1ns/1ps

module dcache (
  input  logic                             clock,
  input  logic                             reset,

  // read port
  input  dcache_pkg::cache_addr_t          rd_addr,
  output logic [dcache_pkg::data_bits-1:0] rd_data,
  output logic                             rd_hit,

  // write port
  input  logic                             wr_en,
  input  logic                             wr_fill,
  input  dcache_pkg::cache_addr_t          wr_addr,
  input  logic [dcache_pkg::data_bits-1:0] wr_data,
  input  logic                             wr_dirty,
  input  logic                             wr_valid,
  output logic                             wr_hit,

  // replacement candidate of the write set
  output dcache_pkg::evict_line_t          evict
);

  import dcache_pkg::*;

  way_mask_t                  way_write;
  way_mask_t                  rd_hits;
  way_mask_t                  wr_hits;
  way_mask_t                  victim;
  way_index_t                 victim_way;
  logic                       alloc;
  cache_line_t [num_way-1:0]  rd_lines;
  cache_line_t [num_way-1:0]  set_lines;

  // input side
  write_steer steer_i (
    .wr_en     (wr_en),
    .wr_fill   (wr_fill),
    .wr_hits   (wr_hits),
    .victim    (victim),
    .way_write (way_write),
    .alloc     (alloc),
    .wr_hit    (wr_hit)
  );

  // way storage
  for (genvar w = 0; w < num_way; w++) begin : g_way
    cache_way way_i (
      .clock    (clock),
      .reset    (reset),
      .write    (way_write[w]),
      .rd_addr  (rd_addr),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_dirty (wr_dirty),
      .wr_valid (wr_valid),
      .rd_hit   (rd_hits[w]),
      .rd_line  (rd_lines[w]),
      .wr_hit   (wr_hits[w]),
      .set_line (set_lines[w])
    );
  end

  // replacement state, indexed by the write set
  plru_tree plru_i (
    .clock      (clock),
    .reset      (reset),
    .set_index  (wr_addr.set_index),
    .alloc      (alloc),
    .victim     (victim),
    .victim_way (victim_way)
  );

  // output side
  hit_select select_i (
    .rd_hits    (rd_hits),
    .rd_lines   (rd_lines),
    .set_lines  (set_lines),
    .victim_way (victim_way),
    .wr_set     (wr_addr.set_index),
    .rd_hit     (rd_hit),
    .rd_data    (rd_data),
    .evict      (evict)
  );

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
// data cache testbench
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;

  import dcache_pkg::*;

  logic                 clock = 1'b0;
  logic                 reset;
  cache_addr_t          rd_addr;
  logic [data_bits-1:0] rd_data;
  logic                 rd_hit;
  logic                 wr_en;
  logic                 wr_fill;
  cache_addr_t          wr_addr;
  logic [data_bits-1:0] wr_data;
  logic                 wr_dirty;
  logic                 wr_valid;
  logic                 wr_hit;
  evict_line_t          evict;

  integer seed;
  int     errors;
  int     checks;

  // scoreboard of every line and the tree bits per set
  cache_line_t        model_lines [num_set][num_way];
  logic [num_set-1:0] model_root;
  logic [num_set-1:0] model_left;
  logic [num_set-1:0] model_right;

  dcache dut_i (
    .clock    (clock),
    .reset    (reset),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_hit   (rd_hit),
    .wr_en    (wr_en),
    .wr_fill  (wr_fill),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_dirty (wr_dirty),
    .wr_valid (wr_valid),
    .wr_hit   (wr_hit),
    .evict    (evict)
  );

  // 20 ns period
  always #10 clock = ~clock;

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  function automatic cache_addr_t make_addr(input logic [tag_bits-1:0] tag,
                                            input logic [set_bits-1:0] set_index,
                                            input logic [offset_bits-1:0] offset);
    cache_addr_t addr;
    addr.tag       = tag;
    addr.set_index = set_index;
    addr.offset    = offset;
    return addr;
  endfunction

  function automatic logic [data_bits-1:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic void model_reset();
    for (int s = 0; s < num_set; s++) begin
      for (int w = 0; w < num_way; w++) begin
        model_lines[s][w] = '0;
      end
    end
    model_root  = '0;
    model_left  = '0;
    model_right = '0;
  endfunction

  // way holding the address, or -1
  function automatic int model_find(input cache_addr_t addr);
    int way;
    way = -1;
    for (int w = 0; w < num_way; w++) begin
      if (model_lines[addr.set_index][w].valid &&
          model_lines[addr.set_index][w].tag == addr.tag) begin
        way = w;
      end
    end
    return way;
  endfunction

  // root clear picks ways 0/1 by left, root set picks 2/3 by right
  function automatic int model_victim(input logic [set_bits-1:0] set_index);
    if (!model_root[set_index]) begin
      return model_left[set_index] ? 1 : 0;
    end
    return model_right[set_index] ? 3 : 2;
  endfunction

  function automatic void model_update(input logic fill, input cache_addr_t addr,
                                       input logic [data_bits-1:0] data,
                                       input logic dirty);
    int way;
    way = model_find(addr);
    if (way < 0 && fill) begin
      way = model_victim(addr.set_index);
      if (model_root[addr.set_index]) begin
        model_right[addr.set_index] = ~model_right[addr.set_index];
      end else begin
        model_left[addr.set_index] = ~model_left[addr.set_index];
      end
      model_root[addr.set_index] = ~model_root[addr.set_index];
    end
    // store miss falls through untouched
    if (way >= 0) begin
      model_lines[addr.set_index][way].valid = 1'b1;
      model_lines[addr.set_index][way].dirty = dirty;
      model_lines[addr.set_index][way].tag   = addr.tag;
      model_lines[addr.set_index][way].data  = data;
    end
  endfunction

  task automatic check_write_side(input string name, input cache_addr_t addr);
    cache_line_t line;
    line = model_lines[addr.set_index][model_victim(addr.set_index)];
    check_value({name, " wr_hit"}, 128'(model_find(addr) >= 0), 128'(wr_hit));
    check_value({name, " evict valid"}, 128'(line.valid), 128'(evict.valid));
    check_value({name, " evict dirty"}, 128'(line.dirty), 128'(evict.dirty));
    check_value({name, " evict set"}, 128'(addr.set_index), 128'(evict.addr.set_index));
    if (line.valid) begin
      check_value({name, " evict tag"}, 128'(line.tag), 128'(evict.addr.tag));
      check_value({name, " evict offset"}, 128'(0), 128'(evict.addr.offset));
      check_value({name, " evict data"}, 128'(line.data), 128'(evict.data));
    end
  endtask

  // present a write address without a strobe
  task automatic probe_write(input string name, input cache_addr_t addr);
    @(posedge clock);
    wr_addr <= addr;
    @(negedge clock);
    check_write_side(name, addr);
  endtask

  task automatic read_check(input string name, input cache_addr_t addr);
    int                   way;
    logic [data_bits-1:0] exp_data;
    @(posedge clock);
    rd_addr <= addr;
    @(negedge clock);
    way = model_find(addr);
    exp_data = (way >= 0) ? model_lines[addr.set_index][way].data : '0;
    check_value({name, " rd_hit"}, 128'(way >= 0), 128'(rd_hit));
    check_value({name, " rd_data"}, 128'(exp_data), 128'(rd_data));
  endtask

  // evict and wr_hit are checked before the edge that takes the write
  task automatic write_op(input string name, input logic fill, input cache_addr_t addr,
                          input logic [data_bits-1:0] data, input logic dirty);
    @(posedge clock);
    wr_en    <= 1'b1;
    wr_fill  <= fill;
    wr_addr  <= addr;
    wr_data  <= data;
    wr_dirty <= dirty;
    wr_valid <= 1'b1;
    @(negedge clock);
    check_write_side(name, addr);
    @(posedge clock);
    wr_en   <= 1'b0;
    wr_fill <= 1'b0;
    model_update(fill, addr, data, dirty);
  endtask

  task automatic test_reset();
    cache_addr_t addr;
    for (int i = 0; i < 4; i++) begin
      addr = make_addr(26'h3000 + 26'(i), 3'(i * 3), 3'(i));
      read_check("reset", addr);
      probe_write("reset", addr);
    end
  endtask

  // ways of set 3 fill in the order 0, 2, 1, 3
  task automatic test_fill_read();
    int          order [4];
    cache_addr_t addr;
    order = '{0, 2, 1, 3};
    for (int k = 0; k < 4; k++) begin
      addr = make_addr(26'h0a0 + 26'(k), 3'd3, 3'(k));
      probe_write("fill_read probe", addr);
      check_value("fill_read order", 128'(order[k]), 128'(dut_i.victim_way));
      write_op("fill_read", 1'b1, addr, random_word(), (k % 2) == 0);
      read_check("fill_read", addr);
    end
    probe_write("fill_read full", make_addr(26'h0a4, 3'd3, 3'd0));
  endtask

  task automatic test_dirty_evict();
    cache_addr_t old_addr;
    cache_addr_t new_addr;
    old_addr = make_addr(26'h0a0, 3'd3, 3'd0);
    new_addr = make_addr(26'h0a4, 3'd3, 3'd5);
    probe_write("dirty_evict probe", new_addr);
    check_value("dirty_evict dirty", 128'(1), 128'(evict.dirty));
    check_value("dirty_evict tag", 128'(26'h0a0), 128'(evict.addr.tag));
    write_op("dirty_evict", 1'b1, new_addr, random_word(), 1'b0);
    read_check("dirty_evict old", old_addr);
    read_check("dirty_evict new", new_addr);
  endtask

  task automatic test_store();
    cache_addr_t          addr;
    logic [data_bits-1:0] data;
    // next victim of set 3 is way 2, tag 0a1
    addr = make_addr(26'h0a1, 3'd3, 3'd2);
    data = random_word();
    write_op("store_hit", 1'b0, addr, data, 1'b1);
    read_check("store_hit", addr);
    probe_write("store_hit tree", addr);
    check_value("store_hit victim data", 128'(data), 128'(evict.data));
    check_value("store_hit victim dirty", 128'(1), 128'(evict.dirty));
    addr = make_addr(26'h0a0, 3'd3, 3'd0);
    write_op("store_miss", 1'b0, addr, random_word(), 1'b1);
    read_check("store_miss", addr);
    probe_write("store_miss tree", addr);
    check_value("store_miss victim tag", 128'(26'h0a1), 128'(evict.addr.tag));
  endtask

  task automatic test_fill_hit();
    cache_addr_t addr;
    addr = make_addr(26'h0a2, 3'd3, 3'd1);
    write_op("fill_hit", 1'b1, addr, random_word(), 1'b0);
    read_check("fill_hit", addr);
    probe_write("fill_hit tree", addr);
    check_value("fill_hit victim tag", 128'(26'h0a1), 128'(evict.addr.tag));
  endtask

  // small tag pool keeps hits and evictions frequent
  task automatic test_random_mix();
    int          op;
    cache_addr_t addr;
    for (int i = 0; i < 300; i++) begin
      op = $unsigned($random(seed)) % 3;
      addr = make_addr(26'h200 + 26'($unsigned($random(seed)) % 6), 3'($random(seed)),
                       3'($random(seed)));
      case (op)
        0: write_op("random fill", 1'b1, addr, random_word(), 1'($random(seed)));
        1: write_op("random store", 1'b0, addr, random_word(), 1'($random(seed)));
        default: read_check("random read", addr);
      endcase
    end
  endtask

  initial begin
    seed   = 67;
    errors = 0;
    checks = 0;
    reset    <= 1'b1;
    rd_addr  <= '0;
    wr_en    <= 1'b0;
    wr_fill  <= 1'b0;
    wr_addr  <= '0;
    wr_data  <= '0;
    wr_dirty <= 1'b0;
    wr_valid <= 1'b0;
    model_reset();
    for (int i = 0; i < 16; i++) begin
      @(posedge clock);
    end
    reset <= 1'b0;

    test_reset();
    test_fill_read();
    test_dirty_evict();
    test_store();
    test_fill_hit();
    test_random_mix();

    $display("errors %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog
  initial begin
    for (int c = 0; c < 5000; c++) begin
      @(posedge clock);
    end
    $display("timeout: tests did not finish within 5000 cycles");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache.f
verilog/dcache_pkg.sv
verilog/write_steer.sv
verilog/cache_way.sv
verilog/plru_tree.sv
verilog/hit_select.sv
verilog/dcache.sv
dv/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module dcache_tb -f dcache.f

./obj_dir/Vdcache_tb > sim.log
cat sim.log

# the testbench prints the pass line only when every check matched
if grep -qx '\*\* PASS \*\*' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
